// File: hdl/tti_tx_pkg.sv
// TTI transmit path package with shared widths, descriptor fields and the data word type.

package tti_tx_pkg;

  // Width of one descriptor word as written by software.
  localparam int unsigned TxDescWidth = 32;

  // Width of one data word in the TX data queue.
  localparam int unsigned TxWordWidth = 32;

  // The message length field and the byte counter share this width.
  localparam int unsigned TxLenWidth = 16;
  localparam int unsigned TxLenLsb = 0; // Length sits in the low half of the descriptor.

  // Fill level reported by each queue.
  localparam int unsigned TxLevelWidth = 16;

  // One data word, seen either whole or as four bytes.
  // The byte view puts byte 0 at the low end, so it goes out first.
  typedef union packed {
    logic [TxWordWidth-1:0] word;
    logic [3:0][7:0]        bytes;
  } tx_word_u;

endpackage

// File: hdl/tti_sync_fifo.sv
// Synchronous FIFO with valid/ready on both sides and a fill level output.

`timescale 1ns/1ps

module tti_sync_fifo #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  input  logic [Width-1:0]                    wdata_i,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output logic [Width-1:0]                    rdata_o,
  output logic [tti_tx_pkg::TxLevelWidth-1:0] level_o
);

  import tti_tx_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
  localparam logic [TxLevelWidth-1:0] FullLevel = TxLevelWidth'(Depth);

  logic [Width-1:0]        mem_q [Depth];
  logic [PtrWidth-1:0]     wr_ptr_q;
  logic [PtrWidth-1:0]     rd_ptr_q;
  logic [TxLevelWidth-1:0] count_q;
  logic [TxLevelWidth-1:0] count_d;
  logic                    ready_q;
  logic                    push;
  logic                    pop;

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  assign wready_o = ready_q;           // Registered, so it stays low through reset.
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rd_ptr_q];
  assign level_o  = count_q;

  always_comb begin
    count_d = count_q;
    case ({push, pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      count_q <= count_d;
      ready_q <= (count_d != FullLevel);
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Storage is written only on an accepted word.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

// File: hdl/tti_tx_width_conv.sv
// Word to byte converter that holds one data word and hands out its bytes low byte first.

`timescale 1ns/1ps

module tti_tx_width_conv (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 word_valid_i,
  output logic                 word_ready_o,
  input  tti_tx_pkg::tx_word_u word_i,
  input  logic                 flush_i,
  output logic                 byte_valid_o,
  input  logic                 byte_ready_i,
  output logic [7:0]           byte_o
);

  import tti_tx_pkg::*;

  tx_word_u   word_q;
  logic       full_q;
  logic [1:0] idx_q;
  logic       byte_take;
  logic       last_byte;
  logic       load;

  assign byte_take = byte_valid_o && byte_ready_i;
  assign last_byte = (idx_q == 2'd3);

  // Refill when empty, or when the final byte of the held word leaves this cycle.
  assign word_ready_o = !full_q || (last_byte && byte_take);
  assign load         = word_valid_i && word_ready_o;

  assign byte_valid_o = full_q;
  assign byte_o       = word_q.bytes[idx_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      idx_q  <= 2'd0;
    end else begin
      if (load) begin
        full_q <= 1'b1;
        idx_q  <= 2'd0;
      end else if (byte_take && last_byte) begin
        full_q <= 1'b0; // Word used up and nothing waiting behind it.
        idx_q  <= 2'd0;
      end else if (flush_i) begin
        idx_q <= 2'd0;
      end else if (byte_take) begin
        idx_q <= idx_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      word_q <= word_i;
    end
  end

endmodule

// File: hdl/descriptor_tx.sv
// TX descriptor handler that gates private reads on queued data, marks the last byte and flushes.

`timescale 1ns/1ps

module descriptor_tx (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Descriptor queue read side.
  input  logic                                tti_tx_desc_queue_rvalid_i,
  output logic                                tti_tx_desc_queue_rready_o,
  input  logic [tti_tx_pkg::TxDescWidth-1:0]  tti_tx_desc_queue_rdata_i,

  // Byte stream from the width converter, plus the data queue level.
  input  logic                                tti_tx_queue_rvalid_i,
  input  logic [tti_tx_pkg::TxLevelWidth-1:0] tti_tx_queue_depth_i,
  output logic                                tti_tx_queue_rready_o,
  input  logic [7:0]                          tti_tx_queue_rdata_i,
  output logic                                tx_queue_flush_o,

  // Target FSM side.
  input  logic                                tx_start_i,
  input  logic                                tx_abort_i,
  output logic                                tx_desc_avail_o,
  output logic [7:0]                          tx_byte_o,
  output logic                                tx_byte_last_o,
  output logic                                tx_byte_valid_o,
  input  logic                                tx_byte_ready_i,

  input  logic                                recovery_mode_enter_i
);

  import tti_tx_pkg::*;

  logic [TxLenWidth-1:0]   desc_len_q;
  logic                    desc_valid_q;
  logic                    tx_pending_q;
  logic                    flush_q;
  logic [TxLenWidth-1:0]   byte_cnt_q;
  logic [TxLenWidth-1:0]   len_words;
  logic [TxLevelWidth:0]   words_avail;
  logic                    abort_req;
  logic                    desc_pop;
  logic                    tx_start;
  logic                    tx_end;
  logic                    byte_take;
  logic                    flush_start;
  logic                    flush_done;

  assign abort_req = tx_abort_i || recovery_mode_enter_i;

  // A descriptor is taken only on a start request with nothing held and no flush going on.
  assign desc_pop = !desc_valid_q && tx_start_i && tti_tx_desc_queue_rvalid_i &&
                    !flush_q && !abort_req;
  assign tti_tx_desc_queue_rready_o = desc_pop;
  assign tx_desc_avail_o = tti_tx_desc_queue_rvalid_i;

  // The converter holds one more word than the queue level shows.
  assign len_words   = desc_len_q >> 2;
  assign words_avail = {1'b0, tti_tx_queue_depth_i} + 1'b1;
  assign tx_start    = !tx_pending_q && desc_valid_q &&
                       (words_avail >= (TxLevelWidth + 1)'(len_words));

  assign byte_take = tti_tx_queue_rvalid_i && tti_tx_queue_rready_o;
  assign tx_end    = tx_pending_q && tx_byte_valid_o && tx_byte_ready_i &&
                     (byte_cnt_q == TxLenWidth'(1));

  // Drain only if a message is actually in flight or waiting for its data.
  assign flush_start = abort_req && !flush_q &&
                       ((tx_pending_q && !tx_end) || (desc_valid_q && !tx_pending_q));
  assign flush_done  = flush_q && tti_tx_queue_rvalid_i && (byte_cnt_q == TxLenWidth'(1));

  assign tx_byte_valid_o = tx_pending_q && tti_tx_queue_rvalid_i;
  assign tx_byte_last_o  = tx_byte_valid_o && (byte_cnt_q == TxLenWidth'(1));
  assign tx_byte_o       = tti_tx_queue_rdata_i;
  assign tti_tx_queue_rready_o = (tx_byte_valid_o && tx_byte_ready_i) ||
                                 (flush_q && tti_tx_queue_rvalid_i);

  assign tx_queue_flush_o = tx_end || flush_done; // Resync the converter at a message edge.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
      tx_pending_q <= 1'b0;
      flush_q      <= 1'b0;
    end else begin
      if (abort_req || tx_end) begin
        desc_valid_q <= 1'b0;
      end else if (desc_pop) begin
        desc_valid_q <= 1'b1;
      end

      if (abort_req || tx_end) begin
        tx_pending_q <= 1'b0;
      end else if (tx_start) begin
        tx_pending_q <= 1'b1;
      end

      if (flush_start) begin
        flush_q <= 1'b1;
      end else if (flush_done) begin
        flush_q <= 1'b0;
      end
    end
  end

  // Counts bytes still owed for the current message, whether sent or drained.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
    end else if (tx_start || (flush_start && !tx_pending_q)) begin
      byte_cnt_q <= desc_len_q;
    end else if (byte_take) begin
      byte_cnt_q <= byte_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_pop) begin
      desc_len_q <= tti_tx_desc_queue_rdata_i[TxLenLsb +: TxLenWidth];
    end
  end

endmodule

// File: hdl/tti_tx_path.sv
// TTI transmit path top level with the descriptor and data queues, converter and handler.

`timescale 1ns/1ps

module tti_tx_path #(
  parameter int unsigned DescFifoDepth = 4,
  parameter int unsigned DataFifoDepth = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               desc_wvalid_i,
  output logic                               desc_wready_o,
  input  logic [tti_tx_pkg::TxDescWidth-1:0] desc_wdata_i,
  input  logic                               data_wvalid_i,
  output logic                               data_wready_o,
  input  tti_tx_pkg::tx_word_u               data_wdata_i,
  input  logic                               tx_start_i,
  input  logic                               tx_abort_i,
  input  logic                               recovery_mode_enter_i,
  output logic                               tx_desc_avail_o,
  output logic [7:0]                         tx_byte_o,
  output logic                               tx_byte_valid_o,
  output logic                               tx_byte_last_o,
  input  logic                               tx_byte_ready_i
);

  import tti_tx_pkg::*;

  logic                    desc_rvalid;
  logic                    desc_rready;
  logic [TxDescWidth-1:0]  desc_rdata;
  logic                    data_rvalid;
  logic                    data_rready;
  logic [TxWordWidth-1:0]  data_rdata;
  logic [TxLevelWidth-1:0] data_level;
  logic                    byte_valid;
  logic                    byte_ready;
  logic [7:0]              byte_data;
  logic                    queue_flush;

  tti_sync_fifo #(
    .Width (TxDescWidth),
    .Depth (DescFifoDepth)
  ) i_desc_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid_i),
    .wready_o (desc_wready_o),
    .wdata_i  (desc_wdata_i),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata),
    .level_o  ()
  );

  tti_sync_fifo #(
    .Width (TxWordWidth),
    .Depth (DataFifoDepth)
  ) i_data_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (data_wvalid_i),
    .wready_o (data_wready_o),
    .wdata_i  (data_wdata_i.word),
    .rvalid_o (data_rvalid),
    .rready_i (data_rready),
    .rdata_o  (data_rdata),
    .level_o  (data_level)
  );

  tti_tx_width_conv i_width_conv (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (data_rvalid),
    .word_ready_o (data_rready),
    .word_i       (data_rdata),
    .flush_i      (queue_flush),
    .byte_valid_o (byte_valid),
    .byte_ready_i (byte_ready),
    .byte_o       (byte_data)
  );

  descriptor_tx i_descriptor_tx (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .tti_tx_desc_queue_rvalid_i (desc_rvalid),
    .tti_tx_desc_queue_rready_o (desc_rready),
    .tti_tx_desc_queue_rdata_i  (desc_rdata),
    .tti_tx_queue_rvalid_i      (byte_valid),
    .tti_tx_queue_depth_i       (data_level),
    .tti_tx_queue_rready_o      (byte_ready),
    .tti_tx_queue_rdata_i       (byte_data),
    .tx_queue_flush_o           (queue_flush),
    .tx_start_i                 (tx_start_i),
    .tx_abort_i                 (tx_abort_i),
    .tx_desc_avail_o            (tx_desc_avail_o),
    .tx_byte_o                  (tx_byte_o),
    .tx_byte_last_o             (tx_byte_last_o),
    .tx_byte_valid_o            (tx_byte_valid_o),
    .tx_byte_ready_i            (tx_byte_ready_i),
    .recovery_mode_enter_i      (recovery_mode_enter_i)
  );

endmodule

// File: dv/tti_tx_path_asserts.sv
// Protocol assertions for the TTI transmit path, checked on its top-level ports.

`timescale 1ns/1ps

module tti_tx_path_asserts (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       desc_wready_o,
  input logic       data_wready_o,
  input logic       tx_abort_i,
  input logic       recovery_mode_enter_i,
  input logic       tx_desc_avail_o,
  input logic [7:0] tx_byte_o,
  input logic       tx_byte_valid_o,
  input logic       tx_byte_last_o,
  input logic       tx_byte_ready_i
);

  int unsigned assert_errors = 0; // Number of failed checks so far.

  // A byte offer holds steady until it is taken, unless the message is cut off.
  valid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && !tx_byte_ready_i && !tx_abort_i && !recovery_mode_enter_i
    |=> tx_byte_valid_o && $stable(tx_byte_o) && $stable(tx_byte_last_o))
    else begin
      assert_errors++;
      $error("tx_byte_valid_o or its byte changed before tx_byte_ready_i");
    end

  last_with_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_last_o |-> tx_byte_valid_o)
    else begin
      assert_errors++;
      $error("tx_byte_last_o high without tx_byte_valid_o");
    end

  // Both queues refuse writes and nothing is offered while reset is held.
  quiet_in_reset_a: assert property (@(posedge clk_i)
    !rst_ni |-> !tx_byte_valid_o && !tx_byte_last_o && !tx_desc_avail_o &&
                !desc_wready_o && !data_wready_o)
    else begin
      assert_errors++;
      $error("Outputs active during reset");
    end

endmodule

bind tti_tx_path tti_tx_path_asserts i_tx_path_asserts (.*);

// File: dv/tti_tx_path_tb.sv
// Testbench for the TTI transmit path with random messages, aborts and a byte-level model.

`timescale 1ns/1ps

module tti_tx_path_tb;

  import tti_tx_pkg::*;

  localparam int unsigned NumMsgs = 24;

  logic clk_i;
  logic rst_ni;
  logic desc_wvalid_i;
  logic desc_wready_o;
  logic [TxDescWidth-1:0] desc_wdata_i;
  logic data_wvalid_i;
  logic data_wready_o;
  tx_word_u data_wdata_i;
  logic tx_start_i;
  logic tx_abort_i;
  logic recovery_mode_enter_i;
  logic tx_desc_avail_o;
  logic [7:0] tx_byte_o;
  logic tx_byte_valid_o;
  logic tx_byte_last_o;
  logic tx_byte_ready_i;

  integer seed = 79;
  tx_word_u msg_words [NumMsgs][8];
  int unsigned msg_len [NumMsgs];
  int unsigned abort_at [NumMsgs]; // Zero means the message runs to its end.
  logic abort_rec [NumMsgs];
  logic [7:0] exp_bytes [$];
  int unsigned exp_lens [$];
  int unsigned cycles = 0;
  int unsigned limit = 0;
  int unsigned msg_pos = 0;
  int unsigned cur_len = 0;
  int unsigned done_count = 0;
  logic started = 1'b0;
  logic prev_hold = 1'b0;
  logic [7:0] prev_byte;
  logic prev_last;

  tti_tx_path #(.DescFifoDepth(4), .DataFifoDepth(16)) i_tti_tx_path (.*);

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic got_last,
                            input logic [7:0] exp, input logic exp_last);
    if (got !== exp || got_last !== exp_last) begin
      report_fail($sformatf(
        "[ERROR] tx_byte_o 0x%02h expected 0x%02h, tx_byte_last_o 0x%0h expected 0x%0h",
        got, exp, got_last, exp_last));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("[ERROR] %s 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic write_desc(input logic [TxDescWidth-1:0] desc);
    desc_wvalid_i = 1'b1;
    desc_wdata_i  = desc;
    while (!desc_wready_o) begin
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2 desc_wvalid_i = 1'b0;
  endtask

  task automatic write_data(input tx_word_u word);
    data_wvalid_i = 1'b1;
    data_wdata_i  = word;
    while (!data_wready_o) begin
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2 data_wvalid_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // The FSM side stalls about one cycle in four.
  initial begin
    tx_byte_ready_i = 1'b0;
    wait (rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      #2 tx_byte_ready_i = (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      report_fail("Timeout: the messages did not finish within the cycle limit.");
    end
    if (i_tti_tx_path.i_tx_path_asserts.assert_errors != 0) begin
      report_fail("A protocol assertion on the top-level ports failed.");
    end
  end

  // Outputs are sampled mid-cycle, where they already show what the next edge will transfer.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!started && tx_byte_valid_o) begin
        report_fail("A byte was offered before the first tx_start_i.");
      end
      if (prev_hold) begin
        check_flag("tx_byte_valid_o", tx_byte_valid_o, 1'b1);
        check_byte(tx_byte_o, tx_byte_last_o, prev_byte, prev_last);
      end
      if (tx_byte_valid_o && tx_byte_ready_i) begin
        if (exp_bytes.size() == 0 || (msg_pos == 0 && exp_lens.size() == 0)) begin
          report_fail("A byte was transferred that the model did not expect.");
        end
        if (msg_pos == 0) cur_len = exp_lens.pop_front();
        check_byte(tx_byte_o, tx_byte_last_o, exp_bytes.pop_front(), msg_pos + 1 == cur_len);
        msg_pos++;
        if (msg_pos == cur_len) begin
          msg_pos = 0;
          done_count++;
        end
      end
      // An abort drops whatever the cut message still owed.
      if ((tx_abort_i || recovery_mode_enter_i) && msg_pos != 0) begin
        repeat (cur_len - msg_pos) void'(exp_bytes.pop_front());
        msg_pos = 0;
        done_count++;
      end
      prev_hold = tx_byte_valid_o && !tx_byte_ready_i && !tx_abort_i && !recovery_mode_enter_i;
      prev_byte = tx_byte_o;
      prev_last = tx_byte_last_o;
      if (tx_start_i) started = 1'b1;
    end
  end

  initial begin
    int unsigned total;
    tx_word_u w;
    rst_ni = 1'b0;
    desc_wvalid_i = 1'b0;
    desc_wdata_i = '0;
    data_wvalid_i = 1'b0;
    data_wdata_i = '0;
    tx_start_i = 1'b0;
    tx_abort_i = 1'b0;
    recovery_mode_enter_i = 1'b0;
    total = 0;
    for (int m = 0; m < NumMsgs; m++) begin
      msg_len[m] = 4 * (($random(seed) & 7) + 1);
      abort_at[m] = 0;
      abort_rec[m] = (($random(seed) & 1) != 0);
      if (($random(seed) & 3) == 0) begin
        abort_at[m] = 1 + ($unsigned($random(seed)) % (msg_len[m] - 2));
      end
      exp_lens.push_back(msg_len[m]);
      for (int i = 0; i < msg_len[m] / 4; i++) begin
        w.word = $random(seed);
        msg_words[m][i] = w;
        for (int b = 0; b < 4; b++) exp_bytes.push_back(w.word[8*b +: 8]);
      end
      total += msg_len[m];
    end
    limit = 40 * total + 2000;
    repeat (16) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    for (int m = 0; m < NumMsgs; m++) begin
      check_flag("tx_desc_avail_o", tx_desc_avail_o, 1'b0);
      write_desc(TxDescWidth'(msg_len[m]));
      check_flag("tx_desc_avail_o", tx_desc_avail_o, 1'b1);
      for (int i = 0; i < msg_len[m] / 4; i++) write_data(msg_words[m][i]);
      tx_start_i = 1'b1; // Held until the handler takes the descriptor.
      do begin
        @(posedge clk_i);
        #2;
      end while (tx_desc_avail_o);
      tx_start_i = 1'b0;
      if (abort_at[m] != 0) begin
        while (msg_pos < abort_at[m]) begin
          @(posedge clk_i);
          #2;
        end
        tx_abort_i = !abort_rec[m];
        recovery_mode_enter_i = abort_rec[m];
        @(posedge clk_i);
        #2;
        tx_abort_i = 1'b0;
        recovery_mode_enter_i = 1'b0;
      end
      while (done_count <= m) begin
        @(posedge clk_i);
        #2;
      end
    end
    if (exp_bytes.size() != 0 || exp_lens.size() != 0) begin
      report_fail("The model still holds bytes that were never transferred.");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: build.f
hdl/tti_tx_pkg.sv
hdl/tti_sync_fifo.sv
hdl/tti_tx_width_conv.sv
hdl/descriptor_tx.sv
hdl/tti_tx_path.sv
dv/tti_tx_path_asserts.sv
dv/tti_tx_path_tb.sv
